/* include/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath and bus widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 13
`define CPU_NUM_REGS 4

// Opcodes that bypass the normal decode
`define CPU_OP_HALT 8'h40
`define CPU_OP_NOP 8'hC0

// Upper nibble of the branch and I/O rows
`define CPU_ROW_BCTR 4'h1
`define CPU_ROW_BCFR 4'h9
`define CPU_ROW_REDC 4'h3
`define CPU_ROW_REDD 4'h7
`define CPU_ROW_WRTC 4'hB
`define CPU_ROW_WRTD 4'hF

`endif

/* src/cpu_pkg.sv */
`include "cpu_settings.svh"

package cpu_pkg;

	typedef logic [`CPU_DATA_W-1:0] byte_t;             // Data byte or register value
	typedef logic [`CPU_ADDR_W-1:0] addr_t;             // Bus address and program counter
	typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_sel_t;
	typedef logic [1:0] cc_t;                           // 00 zero, 01 positive, 10 negative

	// Top three opcode bits of the ALU rows
	typedef enum logic [2:0] {
		alu_lod,
		alu_eor,
		alu_and,
		alu_ior,
		alu_add,
		alu_sub,
		alu_str,
		alu_com
	} alu_op_e;

	typedef enum logic [3:0] {
		st_fetch,
		st_decode,
		st_operand,
		st_execute,
		st_io_req,
		st_io_wrp,
		st_io_fin,
		st_branch,
		st_halted
	} seq_state_e;

endpackage

/* src/register_file.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module register_file (
	input  logic              clk,
	input  logic              reset,
	input  cpu_pkg::reg_sel_t rd_sel,
	input  logic              we,
	input  cpu_pkg::reg_sel_t wr_sel,
	input  cpu_pkg::byte_t    wr_data,
	output cpu_pkg::byte_t    rd_data,
	output cpu_pkg::byte_t    r0
);

	cpu_pkg::byte_t regs [`CPU_NUM_REGS]; // r0 to r3, single bank

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wr_sel] <= wr_data;
		end
	end

	assign rd_data = regs[rd_sel]; // Same-cycle read of rN
	assign r0 = regs[0];           // Register-zero forms always need r0

endmodule

/* src/alu.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module alu (
	input  cpu_pkg::alu_op_e op,
	input  cpu_pkg::byte_t   a,
	input  cpu_pkg::byte_t   b,
	output cpu_pkg::byte_t   result,
	output cpu_pkg::cc_t     cc
);

	always_comb begin
		case (op)
			cpu_pkg::alu_eor: result = a ^ b;
			cpu_pkg::alu_and: result = a & b;
			cpu_pkg::alu_ior: result = a | b;
			cpu_pkg::alu_add: result = a + b;   // Wraps, no carry kept
			cpu_pkg::alu_sub: result = a - b;
			default: result = b;                // lod, str and com pass b
		endcase
	end

	always_comb begin
		if (op == cpu_pkg::alu_com) begin
			// Arithmetic compare, operands are two's complement
			if ($signed(a) > $signed(b)) begin
				cc = 2'b01;
			end else if ($signed(a) < $signed(b)) begin
				cc = 2'b10;
			end else begin
				cc = 2'b00;
			end
		end else if (result[`CPU_DATA_W-1]) begin
			cc = 2'b10;                         // Negative
		end else if (result != '0) begin
			cc = 2'b01;
		end else begin
			cc = 2'b00;
		end
	end

endmodule

/* src/branch_cond.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module branch_cond (
	input  cpu_pkg::byte_t ins,
	input  cpu_pkg::cc_t   cc,
	input  cpu_pkg::addr_t pc,
	input  cpu_pkg::byte_t offset,
	output logic           taken,
	output cpu_pkg::addr_t target
);

	logic [1:0] field;
	cpu_pkg::addr_t disp;

	assign field = ins[1:0]; // Condition to test against cc

	always_comb begin
		if (ins[7:4] == `CPU_ROW_BCFR) begin
			taken = field != cc;
		end else begin
			taken = field == 2'b11 || field == cc; // Field 3 means always
		end
	end

	// Seven-bit signed displacement, bit 7 would select indirect
	assign disp = {{(`CPU_ADDR_W-7){offset[6]}}, offset[6:0]};
	assign target = pc + disp; // pc already past the offset byte

endmodule

/* src/sequencer.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module sequencer (
	input  logic              clk,
	input  logic              reset,
	input  logic              opack,
	input  cpu_pkg::byte_t    dbus_in,
	output cpu_pkg::addr_t    adr,
	output cpu_pkg::byte_t    dbus_out,
	output logic              rw,
	output logic              opreq,
	output logic              wrp,
	output logic              m_io,
	output logic              d_c,
	output cpu_pkg::reg_sel_t rd_sel,
	input  cpu_pkg::byte_t    rd_data,
	input  cpu_pkg::byte_t    r0,
	output logic              we,
	output cpu_pkg::reg_sel_t wr_sel,
	output cpu_pkg::byte_t    wr_data,
	output cpu_pkg::alu_op_e  alu_op,
	output cpu_pkg::byte_t    alu_a,
	output cpu_pkg::byte_t    alu_b,
	input  cpu_pkg::byte_t    alu_result,
	input  cpu_pkg::cc_t      alu_cc,
	output cpu_pkg::cc_t      cc,
	output cpu_pkg::addr_t    pc,
	input  logic              taken,
	input  cpu_pkg::addr_t    target
);

	cpu_pkg::seq_state_e state;
	cpu_pkg::byte_t ir;  // Instruction register
	cpu_pkg::byte_t imm; // Immediate operand
	logic [3:0] row;
	logic [1:0] form;
	logic is_str;
	logic is_alu;
	logic is_branch;
	logic is_io_rd;
	logic is_io_wr;
	logic io_rd_done;

	assign row = ir[7:4];
	assign form = ir[3:2]; // 00 register-zero, 01 immediate
	assign is_str = ir[7:5] == 3'd6;
	assign is_alu = !ir[4] && (form == 2'b00 || (form == 2'b01 && !is_str));
	assign is_branch = form == 2'b10 &&
		(row == `CPU_ROW_BCTR || (row == `CPU_ROW_BCFR && ir[1:0] != 2'b11));
	assign is_io_rd = form == 2'b00 && (row == `CPU_ROW_REDC || row == `CPU_ROW_REDD);
	assign is_io_wr = form == 2'b00 && (row == `CPU_ROW_WRTC || row == `CPU_ROW_WRTD);
	assign io_rd_done = state == cpu_pkg::st_io_fin && opack && !rw;

	assign rd_sel = ir[1:0];
	assign wr_data = alu_result;
	// Register-zero results land in r0, strz writes rN
	assign wr_sel = (state == cpu_pkg::st_execute && form == 2'b00 && !is_str) ? '0 : ir[1:0];
	assign we = io_rd_done || (state == cpu_pkg::st_execute && alu_op != cpu_pkg::alu_com);

	always_comb begin
		alu_op = cpu_pkg::alu_op_e'(ir[7:5]);
		alu_a = r0;
		alu_b = rd_data;
		if (state == cpu_pkg::st_io_fin) begin
			alu_op = cpu_pkg::alu_lod; // I/O read loads the bus byte
			alu_a = rd_data;
			alu_b = dbus_in;
		end else if (form == 2'b01) begin
			alu_a = rd_data;
			alu_b = imm;
		end else if (is_str) begin
			alu_a = rd_data;
			alu_b = r0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cpu_pkg::st_fetch;
			pc <= '0;
			cc <= '0;
			adr <= '0;
			dbus_out <= '0;
			rw <= 1'b0;
			opreq <= 1'b0;
			wrp <= 1'b0;
			m_io <= 1'b1;
			d_c <= 1'b0;
		end else begin
			case (state)
				cpu_pkg::st_fetch: begin
					if (!opreq) begin
						opreq <= 1'b1; // Opcode read at pc
						adr <= pc;
						pc <= pc + 1'b1;
					end else if (opack) begin
						ir <= dbus_in;
						opreq <= 1'b0;
						state <= cpu_pkg::st_decode;
					end
				end
				cpu_pkg::st_decode: begin
					if (ir == `CPU_OP_HALT) begin
						state <= cpu_pkg::st_halted;
					end else if (ir == `CPU_OP_NOP) begin
						state <= cpu_pkg::st_fetch;
					end else if (is_branch) begin
						pc <= pc + 1'b1; // Past the offset byte either way
						if (taken) begin
							opreq <= 1'b1;
							adr <= pc;
							state <= cpu_pkg::st_branch;
						end else begin
							state <= cpu_pkg::st_fetch;
						end
					end else if (is_io_rd || is_io_wr) begin
						state <= cpu_pkg::st_io_req;
					end else if (is_alu && form == 2'b01) begin
						opreq <= 1'b1;
						adr <= pc;
						pc <= pc + 1'b1;
						state <= cpu_pkg::st_operand;
					end else if (is_alu) begin
						state <= cpu_pkg::st_execute;
					end else begin
						state <= cpu_pkg::st_fetch; // Anything else runs as nop
					end
				end
				cpu_pkg::st_operand: begin
					if (opack) begin
						imm <= dbus_in;
						opreq <= 1'b0;
						state <= cpu_pkg::st_execute;
					end
				end
				cpu_pkg::st_execute: begin
					cc <= alu_cc;
					state <= cpu_pkg::st_fetch;
				end
				cpu_pkg::st_io_req: begin
					opreq <= 1'b1;
					rw <= is_io_wr;
					m_io <= 1'b0;
					d_c <= row == `CPU_ROW_REDD || row == `CPU_ROW_WRTD; // Data port
					dbus_out <= rd_data;
					state <= is_io_wr ? cpu_pkg::st_io_wrp : cpu_pkg::st_io_fin;
				end
				cpu_pkg::st_io_wrp: begin
					if (opack) begin
						// Acknowledged before the strobe
						opreq <= 1'b0;
						rw <= 1'b0;
						m_io <= 1'b1;
						d_c <= 1'b0;
						state <= cpu_pkg::st_fetch;
					end else begin
						wrp <= 1'b1;
						state <= cpu_pkg::st_io_fin;
					end
				end
				cpu_pkg::st_io_fin: begin
					if (opack) begin
						if (!rw) begin
							cc <= alu_cc;
						end
						opreq <= 1'b0;
						rw <= 1'b0;
						wrp <= 1'b0;
						m_io <= 1'b1;
						d_c <= 1'b0;
						state <= cpu_pkg::st_fetch;
					end
				end
				cpu_pkg::st_branch: begin
					if (opack) begin
						pc <= target;
						opreq <= 1'b0;
						state <= cpu_pkg::st_fetch;
					end
				end
				default: state <= cpu_pkg::st_halted; // Held until reset
			endcase
		end
	end

endmodule

/* src/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
	input  logic           clk,
	input  logic           reset,
	input  logic           opack,
	input  cpu_pkg::byte_t dbus_in,
	output cpu_pkg::addr_t adr,
	output cpu_pkg::byte_t dbus_out,
	output logic           oeb,
	output logic           rw,
	output logic           opreq,
	output logic           wrp,
	output logic           m_io,
	output logic           d_c
);

	cpu_pkg::reg_sel_t rd_sel;
	cpu_pkg::reg_sel_t wr_sel;
	cpu_pkg::byte_t rd_data;
	cpu_pkg::byte_t r0;
	cpu_pkg::byte_t wr_data;
	logic we;
	cpu_pkg::alu_op_e alu_op;
	cpu_pkg::byte_t alu_a;
	cpu_pkg::byte_t alu_b;
	cpu_pkg::byte_t alu_result;
	cpu_pkg::cc_t alu_cc;
	cpu_pkg::cc_t cc;
	cpu_pkg::addr_t pc;
	cpu_pkg::addr_t target;
	logic taken;

	assign oeb = ~rw; // Bus driven only on writes

	sequencer seq_i (
		.clk(clk), .reset(reset), .opack(opack), .dbus_in(dbus_in),
		.adr(adr), .dbus_out(dbus_out), .rw(rw), .opreq(opreq),
		.wrp(wrp), .m_io(m_io), .d_c(d_c),
		.rd_sel(rd_sel), .rd_data(rd_data), .r0(r0),
		.we(we), .wr_sel(wr_sel), .wr_data(wr_data),
		.alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
		.alu_result(alu_result), .alu_cc(alu_cc),
		.cc(cc), .pc(pc), .taken(taken), .target(target)
	);

	register_file regs_i (
		.clk(clk), .reset(reset), .rd_sel(rd_sel), .we(we),
		.wr_sel(wr_sel), .wr_data(wr_data), .rd_data(rd_data), .r0(r0)
	);

	alu alu_i (.op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result), .cc(alu_cc));

	// Offset byte comes straight off the bus
	branch_cond branch_i (
		.ins(seq_i.ir), .cc(cc), .pc(pc),
		.offset(dbus_in), .taken(taken), .target(target)
	);

endmodule

/* dv/tb_memory.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_memory (
	input  logic           clk,
	input  logic           reset,
	input  logic           opreq,
	input  logic           rw,
	input  logic           m_io,
	input  cpu_pkg::addr_t adr,
	output logic           opack,
	output cpu_pkg::byte_t dbus_in
);

	localparam int PROG_LEN = 76;

	// One entry per byte, grouped roughly by instruction
	localparam logic [7:0] PROGRAM [PROG_LEN] = '{
		8'h04, 8'h5A, 8'h05, 8'hC3, 8'h06, 8'h0F, 8'h07, 8'h80,
		8'h21, 8'hF0, 8'h42, 8'hB0, 8'h63, 8'hF0, 8'h81, 8'hF0,
		8'hA2, 8'hF0, 8'hC1, 8'hF1, 8'h01, 8'h25, 8'h3C, 8'hB1,
		8'h46, 8'hF0, 8'hF2, 8'h67, 8'h11, 8'hF3, 8'h85, 8'h7F,
		8'hF1, 8'hA6, 8'h05, 8'hB2, 8'h33, 8'hF3, 8'h72, 8'hB2,
		8'hE1, 8'h1B, 8'h02, 8'h04, 8'hEE, 8'hE4, 8'h10, 8'h18,
		8'h03, 8'h04, 8'h11, 8'hF0, 8'h04, 8'h05, 8'hE4, 8'h05,
		8'h98, 8'h02, 8'h18, 8'h01, 8'hF0, 8'hE4, 8'h06, 8'h1A,
		8'h01, 8'h00, 8'h19, 8'h7F, 8'h9A, 8'h01, 8'hF0, 8'h99,
		8'h01, 8'hF0, 8'hC0, 8'h40
	};

	cpu_pkg::byte_t image [2**`CPU_ADDR_W];
	logic [31:0] rng;
	logic pending;      // Request seen, wait count chosen
	logic [1:0] wait_left;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	initial begin
		for (int i = 0; i < 2**`CPU_ADDR_W; i++) begin
			image[i] = i[7:0] ^ {3'b000, i[12:8]}; // Unused space differs per address
		end
		for (int i = 0; i < PROG_LEN; i++) begin
			image[i] = PROGRAM[i];
		end
		opack = 1'b0;
		dbus_in = '0;
		rng = 32'h44e1;
		pending = 1'b0;
		wait_left = '0;
	end

	always @(posedge clk) begin
		if (reset) begin
			opack <= 1'b0;
			pending <= 1'b0;
		end else if (opack) begin
			opack <= 1'b0; // One-cycle acknowledge
		end else if (opreq) begin
			if (!pending) begin
				pending <= 1'b1;
				wait_left <= 2'(rng % 3);
				rng <= xorshift(rng);
			end else if (wait_left == 0) begin
				opack <= 1'b1;
				pending <= 1'b0;
				if (!rw && m_io) begin
					dbus_in <= image[adr];
				end else if (!rw) begin
					dbus_in <= rng[15:8]; // I/O read byte
					rng <= xorshift(rng);
				end
			end else begin
				wait_left <= wait_left - 1'b1;
			end
		end
	end

endmodule

/* dv/tb_top.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_top;

	localparam int NUM_INSTR = 53;
	localparam int LIMIT_CYCLES = NUM_INSTR * 40 + 200;

	logic clk;
	logic reset;
	logic opack;
	cpu_pkg::byte_t dbus_in;
	cpu_pkg::addr_t adr;
	cpu_pkg::byte_t dbus_out;
	logic oeb;
	logic rw;
	logic opreq;
	logic wrp;
	logic m_io;
	logic d_c;

	cpu_top dut_i (
		.clk(clk), .reset(reset), .opack(opack), .dbus_in(dbus_in),
		.adr(adr), .dbus_out(dbus_out), .oeb(oeb), .rw(rw),
		.opreq(opreq), .wrp(wrp), .m_io(m_io), .d_c(d_c)
	);

	tb_memory mem_i (
		.clk(clk), .reset(reset), .opreq(opreq), .rw(rw), .m_io(m_io),
		.adr(adr), .opack(opack), .dbus_in(dbus_in)
	);

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
	end

	always #10 clk = ~clk;

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_eq(input string what, input int got, input int exp);
		assert (got == exp) else begin
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			abort_run();
		end
	endtask

	// Result in the low byte, condition code above it
	function automatic logic [9:0] alu_expect(input logic [2:0] op, input logic [7:0] a,
		input logic [7:0] b);
		logic [7:0] res;
		logic [1:0] code;
		case (op)
			3'd1: res = a ^ b;
			3'd2: res = a & b;
			3'd3: res = a | b;
			3'd4: res = a + b;
			3'd5: res = a - b;
			default: res = b;
		endcase
		if (op == 3'd7) begin
			code = ($signed(a) > $signed(b)) ? 2'b01 : ($signed(a) < $signed(b)) ? 2'b10 : 2'b00;
		end else begin
			code = res[7] ? 2'b10 : (res != 0) ? 2'b01 : 2'b00;
		end
		return {code, res};
	endfunction

	// Wait for the next acknowledged transfer and sample the bus
	task automatic next_xfer(output cpu_pkg::addr_t a, output cpu_pkg::byte_t din,
		output cpu_pkg::byte_t dout, output logic mio, output logic wr, output logic dc,
		output logic oe);
		do @(posedge clk); while (!(opreq && opack));
		a = adr;
		din = dbus_in;
		dout = dbus_out;
		mio = m_io;
		wr = rw;
		dc = d_c;
		oe = oeb;
	endtask

	assert property (@(posedge clk) reset |=> (!opreq && !rw && !wrp && m_io && !d_c && adr == 0))
		else begin
			$display("Error at %0t ns: bus outputs not at reset values", $time);
			abort_run();
		end

	assert property (@(posedge clk) disable iff (reset) wrp |-> (opreq && rw)) else begin
		$display("Error at %0t ns: wrp high outside a write request", $time);
		abort_run();
	end

	// Strobe follows the write request one cycle later and holds until opack
	assert property (@(posedge clk) disable iff (reset)
		(opreq && rw && !opack) |=> wrp) else begin
		$display("Error at %0t ns: wrp low during a waiting write request", $time);
		abort_run();
	end

	assert property (@(posedge clk) disable iff (reset) (opreq && !opack) |=>
		($stable(adr) && $stable(rw) && $stable(m_io) && $stable(d_c) &&
		$stable(dbus_out))) else begin
		$display("Error at %0t ns: bus changed while waiting for opack", $time);
		abort_run();
	end

	initial begin : watchdog
		#(LIMIT_CYCLES * 20);
		$display("Watchdog expired after %0d cycles, the run did not finish", LIMIT_CYCLES);
		abort_run();
	end

	initial begin : model
		cpu_pkg::byte_t regs [4];
		cpu_pkg::cc_t cc;
		cpu_pkg::addr_t pc;
		cpu_pkg::addr_t a;
		cpu_pkg::byte_t din;
		cpu_pkg::byte_t dout;
		cpu_pkg::byte_t op;
		logic mio;
		logic wr;
		logic dc;
		logic oe;
		logic halted;
		logic taken;
		logic [9:0] r;
		int off;
		regs = '{default: '0};
		cc = '0;
		pc = '0;
		halted = 1'b0;
		wait (!reset);
		while (!halted) begin
			next_xfer(a, din, dout, mio, wr, dc, oe);
			check_eq("opcode fetch address", a, pc);
			check_eq("opcode fetch m_io", mio, 1);
			check_eq("opcode fetch rw", wr, 0);
			check_eq("opcode fetch oeb", oe, 1);
			op = din;
			pc = pc + 1'b1;
			if (op == `CPU_OP_HALT) begin
				halted = 1'b1;
			end else if (op == `CPU_OP_NOP) begin
				// No bus cycle, registers and cc untouched
			end else if (!op[4] && op[3:2] == 2'b00) begin
				if (op[7:5] == 3'd6) begin
					regs[op[1:0]] = regs[0]; // strz
					r = alu_expect(3'd6, 8'h00, regs[0]);
				end else begin
					r = alu_expect(op[7:5], regs[0], regs[op[1:0]]);
					if (op[7:5] != 3'd7) regs[0] = r[7:0];
				end
				cc = r[9:8];
			end else if (!op[4] && op[3:2] == 2'b01 && op[7:5] != 3'd6) begin
				next_xfer(a, din, dout, mio, wr, dc, oe);
				check_eq("immediate address", a, pc);
				pc = pc + 1'b1;
				r = alu_expect(op[7:5], regs[op[1:0]], din);
				if (op[7:5] != 3'd7) regs[op[1:0]] = r[7:0];
				cc = r[9:8];
			end else if (op[3:2] == 2'b10 && (op[7:4] == `CPU_ROW_BCTR ||
				(op[7:4] == `CPU_ROW_BCFR && op[1:0] != 2'b11))) begin
				if (op[7:4] == `CPU_ROW_BCTR) taken = op[1:0] == 2'b11 || op[1:0] == cc;
				else taken = op[1:0] != cc;
				if (taken) begin
					next_xfer(a, din, dout, mio, wr, dc, oe);
					check_eq("branch offset address", a, pc);
					off = din[6:0];
					if (din[6]) begin
						off = off - 128; // Seven-bit two's complement
					end
					pc = cpu_pkg::addr_t'(pc + 1 + off);
				end else begin
					pc = pc + 1'b1;     // Offset byte skipped
				end
			end else if (op[3:2] == 2'b00 &&
				(op[7:4] == `CPU_ROW_REDC || op[7:4] == `CPU_ROW_REDD)) begin
				next_xfer(a, din, dout, mio, wr, dc, oe);
				check_eq("I/O read m_io", mio, 0);
				check_eq("I/O read rw", wr, 0);
				check_eq("I/O read oeb", oe, 1);
				check_eq("I/O read d_c", dc, op[7:4] == `CPU_ROW_REDD);
				regs[op[1:0]] = din;
				r = alu_expect(3'd0, 8'h00, din);
				cc = r[9:8];
			end else if (op[3:2] == 2'b00 &&
				(op[7:4] == `CPU_ROW_WRTC || op[7:4] == `CPU_ROW_WRTD)) begin
				next_xfer(a, din, dout, mio, wr, dc, oe);
				check_eq("I/O write m_io", mio, 0);
				check_eq("I/O write rw", wr, 1);
				check_eq("I/O write oeb", oe, 0);
				check_eq("I/O write d_c", dc, op[7:4] == `CPU_ROW_WRTD);
				check_eq("I/O write data", dout, regs[op[1:0]]);
			end
		end
		// Halted core must stay off the bus
		repeat (100) begin
			@(posedge clk);
			assert (!opreq) else begin
				$display("Request raised at %0t ns after the halt opcode", $time);
				abort_run();
			end
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

/* sim.f */
+incdir+include
src/cpu_pkg.sv
src/register_file.sv
src/alu.sv
src/branch_cond.sv
src/sequencer.sv
src/cpu_top.sv
dv/tb_memory.sv
dv/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := FAIL: see errors above

SOURCES := $(wildcard src/*.sv dv/*.sv include/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
